// File: design/ghash_pkg.sv
`default_nettype none

package ghash_pkg;

    // block and beat sizes
    localparam int NB_BLOCK = 128;
    localparam int N_BLOCKS = 2;
    localparam int NB_DATA = N_BLOCKS * NB_BLOCK;
    localparam int NB_APB_ADDR = 8;

    // GCM reduction constant, x^128 + x^7 + x^2 + x + 1 in reflected order
    localparam logic [NB_BLOCK-1:0] GCM_R = {8'hE1, 120'd0};

    // register map
    localparam logic [NB_APB_ADDR-1:0] ADDR_KEY0 = 8'h00;
    localparam logic [NB_APB_ADDR-1:0] ADDR_KEY1 = 8'h04;
    localparam logic [NB_APB_ADDR-1:0] ADDR_KEY2 = 8'h08;
    localparam logic [NB_APB_ADDR-1:0] ADDR_KEY3 = 8'h0C;
    localparam logic [NB_APB_ADDR-1:0] ADDR_CTRL = 8'h10;
    localparam logic [NB_APB_ADDR-1:0] ADDR_TAG0 = 8'h20;
    localparam logic [NB_APB_ADDR-1:0] ADDR_TAG1 = 8'h24;
    localparam logic [NB_APB_ADDR-1:0] ADDR_TAG2 = 8'h28;
    localparam logic [NB_APB_ADDR-1:0] ADDR_TAG3 = 8'h2C;

    // upper data half is the first block in hash order
    typedef struct packed {
        logic                sop;
        logic                valid;
        logic                last;
        logic [N_BLOCKS-1:0] skip;
        logic [NB_DATA-1:0]  data;
    } ghash_beat_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [NB_APB_ADDR-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [NB_BLOCK-1:0] h1;
        logic [NB_BLOCK-1:0] h2;
    } key_pow_t;

endpackage

`default_nettype wire

// File: design/gf128_mult.sv
`timescale 1ns/10ps
`default_nettype none

module gf128_mult
    import ghash_pkg::*;
(
    input  wire logic [NB_BLOCK-1:0] i_a,
    input  wire logic [NB_BLOCK-1:0] i_b,
    output logic      [NB_BLOCK-1:0] o_p
);

    logic [NB_BLOCK-1:0] z;
    logic [NB_BLOCK-1:0] v;

    // GCM bit order: bit 127 of the vector is x^0
    always_comb
    begin
        z = '0;
        v = i_b;
        for (int i = NB_BLOCK - 1; i >= 0; i--)
        begin
            if (i_a[i])
            begin
                z = z ^ v;
            end
            // shift toward higher powers, reduce on overflow
            if (v[0])
            begin
                v = (v >> 1) ^ GCM_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
    end

    assign o_p = z;

endmodule

`default_nettype wire

// File: design/h_key_power_table.sv
`timescale 1ns/10ps
`default_nettype none

module h_key_power_table
    import ghash_pkg::*;
(
    input  wire logic                tb_i_clock,
    input  wire logic                i_reset,
    input  wire logic                i_commit,
    input  wire logic [NB_BLOCK-1:0] i_h_key,
    output key_pow_t                 o_key_pow,
    output logic                     o_key_ready
);

    logic [NB_BLOCK-1:0] h_sq;

    // H * H for the first block of a full beat
    gf128_mult mult_sq
    (
        .i_a (i_h_key),
        .i_b (i_h_key),
        .o_p (h_sq)
    );

    // both powers move together so the core never sees a mixed pair
    always_ff @(posedge tb_i_clock)
    begin
        if (i_commit)
        begin
            o_key_pow.h1 <= i_h_key;
            o_key_pow.h2 <= h_sq;
        end
    end

    // sticky until reset
    always_ff @(posedge tb_i_clock)
    begin
        if (i_reset)
        begin
            o_key_ready <= 1'b0;
        end
        else if (i_commit)
        begin
            o_key_ready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/ghash_core.sv
`timescale 1ns/10ps
`default_nettype none

module ghash_core
    import ghash_pkg::*;
(
    input  wire logic                tb_i_clock,
    input  wire logic                i_reset,
    input  wire ghash_beat_t         i_beat,
    input  wire key_pow_t            i_key_pow,
    input  wire logic                i_key_ready,
    output logic      [NB_BLOCK-1:0] o_tag,
    output logic                     o_done
);

    logic                take;
    logic [NB_BLOCK-1:0] y_q;
    logic [NB_BLOCK-1:0] y_base;
    logic [NB_BLOCK-1:0] y_next;
    logic [NB_BLOCK-1:0] a0;
    logic [NB_BLOCK-1:0] a1;
    logic [NB_BLOCK-1:0] hi_op;
    logic [NB_BLOCK-1:0] hi_key;
    logic [NB_BLOCK-1:0] lo_op;
    logic [NB_BLOCK-1:0] p_hi;
    logic [NB_BLOCK-1:0] p_lo;

    // beats arriving before the key powers exist are lost
    assign take = i_beat.valid & i_key_ready;

    assign a0 = i_beat.data[NB_DATA-1:NB_BLOCK];
    assign a1 = i_beat.data[NB_BLOCK-1:0];

    // a new message starts from a zero hash
    assign y_base = i_beat.sop ? '0 : y_q;

    // operand and key power per multiplier
    always_comb
    begin
        hi_op = y_base ^ a0;
        hi_key = i_key_pow.h1;
        lo_op = a1;
        if (i_beat.skip == 2'b00)
        begin
            hi_key = i_key_pow.h2;
        end
        // A0 skipped, so the running hash rides on A1
        if (i_beat.skip[1])
        begin
            lo_op = y_base ^ a1;
        end
    end

    gf128_mult mult_hi
    (
        .i_a (hi_op),
        .i_b (hi_key),
        .o_p (p_hi)
    );

    gf128_mult mult_lo
    (
        .i_a (lo_op),
        .i_b (i_key_pow.h1),
        .o_p (p_lo)
    );

    // combiner: drop the product of a skipped block
    always_comb
    begin
        case (i_beat.skip)
            2'b00:
            begin
                y_next = p_hi ^ p_lo;
            end
            2'b01:
            begin
                y_next = p_hi;
            end
            2'b10:
            begin
                y_next = p_lo;
            end
            default:
            begin
                y_next = y_base;
            end
        endcase
    end

    always_ff @(posedge tb_i_clock)
    begin
        if (i_reset)
        begin
            y_q <= '0;
        end
        else if (take)
        begin
            y_q <= y_next;
        end
    end

    // tag holds until the next message closes
    always_ff @(posedge tb_i_clock)
    begin
        if (i_reset)
        begin
            o_tag <= '0;
            o_done <= 1'b0;
        end
        else
        begin
            o_done <= take & i_beat.last;
            if (take && i_beat.last)
            begin
                o_tag <= y_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ghash_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ghash_apb_regs
    import ghash_pkg::*;
(
    input  wire logic                tb_i_clock,
    input  wire logic                i_reset,
    input  wire apb_req_t            i_apb,
    output apb_rsp_t                 o_apb,
    output logic                     o_commit,
    output logic      [NB_BLOCK-1:0] o_h_key,
    input  wire logic [NB_BLOCK-1:0] i_tag,
    input  wire logic                i_done,
    input  wire logic                i_key_ready
);

    logic                access;
    logic                wr;
    logic                mapped;
    logic                tag_hit;
    logic                err;
    logic                tag_valid;
    logic [31:0]         rdata;
    logic [NB_BLOCK-1:0] tag_q;

    assign access = i_apb.psel & i_apb.penable;
    assign err = access & (~mapped | (i_apb.pwrite & tag_hit));
    assign wr = access & i_apb.pwrite & ~err;

    // address decode and read mux
    always_comb
    begin
        rdata = '0;
        mapped = 1'b1;
        tag_hit = 1'b0;
        case (i_apb.paddr)
            ADDR_KEY0: rdata = o_h_key[31:0];
            ADDR_KEY1: rdata = o_h_key[63:32];
            ADDR_KEY2: rdata = o_h_key[95:64];
            ADDR_KEY3: rdata = o_h_key[127:96];
            ADDR_CTRL: rdata = {30'd0, tag_valid, i_key_ready};
            ADDR_TAG0:
            begin
                rdata = tag_q[31:0];
                tag_hit = 1'b1;
            end
            ADDR_TAG1:
            begin
                rdata = tag_q[63:32];
                tag_hit = 1'b1;
            end
            ADDR_TAG2:
            begin
                rdata = tag_q[95:64];
                tag_hit = 1'b1;
            end
            ADDR_TAG3:
            begin
                rdata = tag_q[127:96];
                tag_hit = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    // no wait states
    always_comb
    begin
        o_apb.prdata = err ? 32'd0 : rdata;
        o_apb.pready = 1'b1;
        o_apb.pslverr = err;
    end

    always_ff @(posedge tb_i_clock)
    begin
        if (wr)
        begin
            case (i_apb.paddr)
                ADDR_KEY0: o_h_key[31:0] <= i_apb.pwdata;
                ADDR_KEY1: o_h_key[63:32] <= i_apb.pwdata;
                ADDR_KEY2: o_h_key[95:64] <= i_apb.pwdata;
                ADDR_KEY3: o_h_key[127:96] <= i_apb.pwdata;
                default: ;
            endcase
        end
        if (i_done)
        begin
            tag_q <= i_tag;
        end
    end

    // KEY3 write completes the key
    always_ff @(posedge tb_i_clock)
    begin
        if (i_reset)
        begin
            o_commit <= 1'b0;
            tag_valid <= 1'b0;
        end
        else
        begin
            o_commit <= wr & (i_apb.paddr == ADDR_KEY3);
            if (i_done)
            begin
                tag_valid <= 1'b1;
            end
            else if (wr && i_apb.paddr == ADDR_CTRL && i_apb.pwdata[1])
            begin
                tag_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ghash_top.sv
`timescale 1ns/10ps
`default_nettype none

module ghash_top
    import ghash_pkg::*;
(
    input  wire logic                tb_i_clock,
    input  wire logic                i_reset,
    input  wire apb_req_t            i_apb,
    output apb_rsp_t                 o_apb,
    input  wire ghash_beat_t         i_beat,
    output logic      [NB_BLOCK-1:0] o_tag,
    output logic                     o_done
);

    logic                commit;
    logic [NB_BLOCK-1:0] h_key;
    key_pow_t            key_pow;
    logic                key_ready;

    // software side
    ghash_apb_regs ghash_apb_regs_i
    (
        .tb_i_clock  (tb_i_clock),
        .i_reset     (i_reset),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .o_commit    (commit),
        .o_h_key     (h_key),
        .i_tag       (o_tag),
        .i_done      (o_done),
        .i_key_ready (key_ready)
    );

    h_key_power_table h_key_power_table_i
    (
        .tb_i_clock  (tb_i_clock),
        .i_reset     (i_reset),
        .i_commit    (commit),
        .i_h_key     (h_key),
        .o_key_pow   (key_pow),
        .o_key_ready (key_ready)
    );

    // hash datapath
    ghash_core ghash_core_i
    (
        .tb_i_clock  (tb_i_clock),
        .i_reset     (i_reset),
        .i_beat      (i_beat),
        .i_key_pow   (key_pow),
        .i_key_ready (key_ready),
        .o_tag       (o_tag),
        .o_done      (o_done)
    );

endmodule

`default_nettype wire

// File: bench/ghash_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module ghash_assertions
    import ghash_pkg::*;
(
    input  wire logic        tb_i_clock,
    input  wire logic        i_reset,
    input  wire ghash_beat_t i_beat,
    input  wire logic        i_key_ready,
    input  wire logic        i_done
);

    int   failures = 0;
    logic last_taken;

    assign last_taken = i_beat.valid & i_key_ready & i_beat.last;

    // done is a single-cycle pulse
    done_single_pulse: assert property (@(posedge tb_i_clock) disable iff (i_reset)
        i_done |=> !i_done)
    else
    begin
        failures++;
        $error("o_done high on two consecutive cycles");
    end

    done_follows_last: assert property (@(posedge tb_i_clock) disable iff (i_reset)
        last_taken |=> i_done)
    else
    begin
        failures++;
        $error("o_done missing one cycle after a taken last beat");
    end

    // no spurious pulse
    done_has_cause: assert property (@(posedge tb_i_clock) disable iff (i_reset)
        i_done |-> $past(last_taken))
    else
    begin
        failures++;
        $error("o_done high without a taken last beat in the previous cycle");
    end

    quiet_in_reset: assert property (@(posedge tb_i_clock)
        i_reset |=> (!i_done && !i_key_ready))
    else
    begin
        failures++;
        $error("o_done or key_ready high during reset");
    end

endmodule

bind ghash_core ghash_assertions ghash_assertions_i
(
    .tb_i_clock  (tb_i_clock),
    .i_reset     (i_reset),
    .i_beat      (i_beat),
    .i_key_ready (i_key_ready),
    .i_done      (o_done)
);

`default_nettype wire

// File: bench/tb_ghash_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ghash_top
    import ghash_pkg::*;
();

    logic                tb_i_clock;
    logic                i_reset;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    ghash_beat_t         beat;
    logic [NB_BLOCK-1:0] tag;
    logic                done;

    int                  seed = 92109;
    string               test_name = "reset";
    int                  done_count = 0;
    logic [NB_BLOCK-1:0] exp_tag;
    ghash_beat_t         msg_q[$];
    ghash_beat_t         stream_q[$];
    logic [NB_BLOCK-1:0] exp_q[$];

    ghash_top ghash_top_i
    (
        .tb_i_clock (tb_i_clock),
        .i_reset    (i_reset),
        .i_apb      (apb_req),
        .o_apb      (apb_rsp),
        .i_beat     (beat),
        .o_tag      (tag),
        .o_done     (done)
    );

    always #2 tb_i_clock = ~tb_i_clock;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [NB_BLOCK-1:0] expected,
                               input logic [NB_BLOCK-1:0] actual);
        assert (actual === expected)
        else
        begin
            stop_with_error($sformatf("Fail %s (%s): expected %h, actual %h",
                                      test_name, what, expected, actual));
        end
    endtask

    // GCM multiply as in SP 800-38D
    // spec bit 0 of a block is the msb here
    function automatic logic [NB_BLOCK-1:0] gf_mul_ref(input logic [NB_BLOCK-1:0] x,
                                                      input logic [NB_BLOCK-1:0] y);
        logic [NB_BLOCK-1:0] z;
        logic [NB_BLOCK-1:0] v;
        z = '0;
        v = y;
        for (int i = 0; i < 128; i++)
        begin
            if (x[127 - i])
                z = z ^ v;
            if (v[0])
                v = (v >> 1) ^ {8'hE1, 120'd0};
            else
                v = v >> 1;
        end
        return z;
    endfunction

    // plain block-serial GHASH over the blocks that are not skipped
    function automatic logic [NB_BLOCK-1:0] ghash_ref(input logic [NB_BLOCK-1:0] h,
                                                     input ghash_beat_t beats[$]);
        logic [NB_BLOCK-1:0] y;
        y = '0;
        foreach (beats[i])
        begin
            if (beats[i].sop)
                y = '0;
            if (!beats[i].skip[1])
                y = gf_mul_ref(y ^ beats[i].data[255:128], h);
            if (!beats[i].skip[0])
                y = gf_mul_ref(y ^ beats[i].data[127:0], h);
        end
        return y;
    endfunction

    function automatic logic [NB_BLOCK-1:0] rand_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic ghash_beat_t make_beat(input logic sop, input logic last,
                                              input logic [1:0] skip,
                                              input logic [NB_BLOCK-1:0] a0,
                                              input logic [NB_BLOCK-1:0] a1);
        ghash_beat_t b;
        b.sop = sop;
        b.valid = 1'b1;
        b.last = last;
        b.skip = skip;
        b.data = {a0, a1};
        return b;
    endfunction

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int cycles;
        @(posedge tb_i_clock);
        apb_req.psel <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite <= write;
        apb_req.paddr <= addr;
        apb_req.pwdata <= wdata;
        @(posedge tb_i_clock);
        apb_req.penable <= 1'b1;
        @(negedge tb_i_clock);
        cycles = 0;
        while (!apb_rsp.pready)
        begin
            cycles++;
            if (cycles > 20)
                stop_with_error("timeout waiting for APB pready");
            @(negedge tb_i_clock);
        end
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge tb_i_clock);
        apb_req.psel <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic read_check(input string what, input logic [7:0] addr,
                              input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] data;
        logic        err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value({what, " pslverr"}, exp_err, err);
        check_value(what, exp_data, data);
    endtask

    task automatic write_check(input string what, input logic [7:0] addr,
                               input logic [31:0] data, input logic exp_err);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_value({what, " pslverr"}, exp_err, err);
    endtask

    task automatic load_key(input logic [NB_BLOCK-1:0] h);
        write_check("key0", ADDR_KEY0, h[31:0], 1'b0);
        write_check("key1", ADDR_KEY1, h[63:32], 1'b0);
        write_check("key2", ADDR_KEY2, h[95:64], 1'b0);
        write_check("key3", ADDR_KEY3, h[127:96], 1'b0);
    endtask

    // move the built message onto the stream and note its tag
    task automatic queue_message(input logic [NB_BLOCK-1:0] h, output logic [NB_BLOCK-1:0] t);
        t = ghash_ref(h, msg_q);
        exp_q.push_back(t);
        foreach (msg_q[i])
        begin
            stream_q.push_back(msg_q[i]);
        end
        msg_q.delete();
    endtask

    task automatic run_stream(input int n_tags);
        int target;
        int cycles;
        target = done_count + n_tags;
        while (stream_q.size() > 0)
        begin
            @(posedge tb_i_clock);
            beat <= stream_q.pop_front();
        end
        @(posedge tb_i_clock);
        beat <= '0;
        cycles = 0;
        while (done_count < target)
        begin
            @(posedge tb_i_clock);
            cycles++;
            if (cycles > 50)
                stop_with_error("timeout waiting for o_done");
        end
    endtask

    task automatic send_reference_message(input logic [NB_BLOCK-1:0] h);
        logic [NB_BLOCK-1:0] t;
        msg_q.push_back(make_beat(1'b1, 1'b0, 2'b00, {16{8'hAA}}, {16{8'hBB}}));
        msg_q.push_back(make_beat(1'b0, 1'b0, 2'b00, {16{8'hCC}}, {16{8'hDD}}));
        msg_q.push_back(make_beat(1'b0, 1'b0, 2'b00, {16{8'h00}}, {16{8'h01}}));
        msg_q.push_back(make_beat(1'b0, 1'b0, 2'b00, {16{8'h02}}, {16{8'h03}}));
        // length block alone with 512 bits each of AAD and text
        msg_q.push_back(make_beat(1'b0, 1'b1, 2'b10, '0, {64'd512, 64'd512}));
        queue_message(h, t);
        run_stream(1);
    endtask

    // compare every done pulse against the oldest expected tag
    always @(negedge tb_i_clock)
    begin
        if (!i_reset && done === 1'b1)
        begin
            assert (exp_q.size() > 0)
            else
            begin
                stop_with_error("o_done pulsed with no message outstanding");
            end
            exp_tag = exp_q.pop_front();
            check_value("tag", exp_tag, tag);
            done_count++;
        end
    end

    initial
    begin
        logic [NB_BLOCK-1:0] h;
        logic [NB_BLOCK-1:0] rb[10];
        logic [NB_BLOCK-1:0] t;
        tb_i_clock = 1'b0;
        i_reset = 1'b1;
        apb_req = '0;
        beat = '0;
        repeat (5) @(posedge tb_i_clock);
        i_reset <= 1'b0;
        @(negedge tb_i_clock);
        check_value("o_done after reset", 1'b0, done);
        read_check("ctrl after reset", ADDR_CTRL, 32'd0, 1'b0);
        h = 128'hACBEF20579B4B8EBCE889BAC8732DAD7;
        load_key(h);
        read_check("ctrl key_ready", ADDR_CTRL, 32'd1, 1'b0);

        test_name = "single message";
        send_reference_message(h);

        test_name = "skip handling";
        foreach (rb[i])
            rb[i] = rand_block();
        msg_q.push_back(make_beat(1'b1, 1'b0, 2'b00, rb[0], rb[1]));
        msg_q.push_back(make_beat(1'b0, 1'b0, 2'b01, rb[2], rb[3]));
        msg_q.push_back(make_beat(1'b0, 1'b0, 2'b10, rb[4], rb[5]));
        msg_q.push_back(make_beat(1'b0, 1'b0, 2'b11, rb[6], rb[7]));
        msg_q.push_back(make_beat(1'b0, 1'b1, 2'b00, rb[8], rb[9]));
        queue_message(h, t);
        run_stream(1);

        test_name = "back to back";
        for (int m = 0; m < 3; m++)
        begin
            for (int b = 0; b < 4 - m; b++)
            begin
                msg_q.push_back(make_beat(b == 0, b == 3 - m, (b == 3 - m) ? 2'b10 : 2'b00,
                                          rand_block(), rand_block()));
            end
            queue_message(h, t);
        end
        run_stream(3);

        test_name = "registers";
        read_check("ctrl tag_valid", ADDR_CTRL, 32'd3, 1'b0);
        read_check("tag0", ADDR_TAG0, t[31:0], 1'b0);
        read_check("tag1", ADDR_TAG1, t[63:32], 1'b0);
        read_check("tag2", ADDR_TAG2, t[95:64], 1'b0);
        read_check("tag3", ADDR_TAG3, t[127:96], 1'b0);
        write_check("clear tag_valid", ADDR_CTRL, 32'd2, 1'b0);
        read_check("ctrl cleared", ADDR_CTRL, 32'd1, 1'b0);
        read_check("unmapped read", 8'h40, 32'd0, 1'b1);
        write_check("tag0 write", ADDR_TAG0, 32'hFFFF_FFFF, 1'b1);

        test_name = "rekey";
        h = rand_block();
        load_key(h);
        send_reference_message(h);

        if (ghash_top_i.ghash_core_i.ghash_assertions_i.failures == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            stop_with_error("bound assertions on ghash_core reported failures");
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
design/ghash_pkg.sv
design/gf128_mult.sv
design/h_key_power_table.sv
design/ghash_core.sv
design/ghash_apb_regs.sv
design/ghash_top.sv
bench/ghash_assertions.sv
bench/tb_ghash_top.sv
